//--- common/trace_pkg.sv
// Pipeline trace package

package trace_pkg;

    localparam int tag_w      = 8;                   // Instruction tag, wraps mod 256
    localparam int fifo_depth = 16;                  // Records held in the queue
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam int stall_max  = 15;                  // Decode stall count saturates here

    // Host register map
    localparam logic [3:0] reg_lo   = 4'h0;          // Record word 0
    localparam logic [3:0] reg_hi   = 4'h4;          // Record word 1, read pops
    localparam logic [3:0] reg_stat = 4'h8;          // Level and overflow count

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    ////////////////////////////////////////////////////////////////////
    // CPU side
    ////////////////////////////////////////////////////////////////////

    // One word per cycle, each field owned by a different stage
    typedef struct packed {
        logic [15:0] fetch_pc;       // Instruction in fetch
        logic [7:0]  decode_opcode;  // Instruction in decode
        logic [15:0] exe_result;     // Instruction in execute
        logic        mem_wr;         // Instruction in memory
        logic        wb_en;          // Instruction in write-back
        logic [4:0]  wb_reg;
        logic        stall;          // Fetch and decode hold
    } stage_in_t;

    typedef struct packed {
        logic             vld;
        logic [tag_w-1:0] tag;
    } tag_slot_t;

    typedef struct packed {
        tag_slot_t fetch;
        tag_slot_t decode;
        tag_slot_t exe;
        tag_slot_t mem;
        tag_slot_t wb;
    } stage_tags_t;

    ////////////////////////////////////////////////////////////////////
    // Trace record and host bus
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [15:0]      pc;
        logic [7:0]       opcode;
        logic [3:0]       stall_cnt;
        logic             mem_wr;
        logic             wb_en;
        logic [4:0]       wb_reg;
        logic [4:0]       rsv;        // Always zero
        logic [15:0]      result;
    } trace_rec_t;

    // Same 64 bits seen as two bus words, word 0 is the low half
    typedef union packed {
        trace_rec_t       rec;
        logic [1:0][31:0] word;
    } trace_rec_u;

    typedef struct packed {
        logic        awvalid;
        logic [3:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic        bready;
        logic        arvalid;
        logic [3:0]  araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

endpackage

//--- verilog/stage_capture.sv
// CPU stage bus capture
`timescale 1ns/1ns

module stage_capture (
    input  logic                clk,
    input  logic                rst_n,
    input  trace_pkg::stage_in_t cpu_in,     // Sampled every cycle, no handshake
    output trace_pkg::stage_in_t stage_q,
    output logic [3:0]          stall_cnt   // Stall run of the instruction in decode
);

    import trace_pkg::*;

    ////////////////////////////////////////////////////////////////////
    // Bus register
    ////////////////////////////////////////////////////////////////////

    // Reset value reads as a stalled bus so the tracker starts no fetch early
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_q       <= '0;
            stage_q.stall <= 1'b1;
        end else begin
            stage_q <= cpu_in;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Decode stall counter
    ////////////////////////////////////////////////////////////////////

    // Counts on the registered bus so it lines up with the tracker.
    // An unstalled stage_q cycle is the one where decode hands over;
    // the count is read then and cleared at the same edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stall_cnt <= '0;
        end else if (!stage_q.stall) begin
            stall_cnt <= '0;                                     // Handed on, start over
        end else if (stall_cnt < 4'(stall_max)) begin
            stall_cnt <= stall_cnt + 4'd1;                       // Decode held one more
        end
    end

    // Saturation holds across a long stall burst
    a_stall_sat : assert property (
        @(posedge clk) disable iff (!rst_n)
        stall_cnt == 4'(stall_max) && stage_q.stall |=> stall_cnt == 4'(stall_max)
    );

endmodule

//--- tracker/pipe_tag_tracker.sv
// Five stage tag tracker
`timescale 1ns/1ns

module pipe_tag_tracker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,   // From the registered bus
    output trace_pkg::stage_tags_t tags
);

    import trace_pkg::*;

    stage_tags_t      tags_q;
    logic [tag_w-1:0] fetch_ctr;           // Next tag handed to fetch
    logic [tag_w-1:0] last_wb_tag;         // Previous retired tag
    logic             wb_seen;             // At least one retire since reset

    ////////////////////////////////////////////////////////////////////
    // Stage advance
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tags_q    <= '0;                // All stages empty
            fetch_ctr <= '0;
        end else begin
            // Back end never waits
            tags_q.wb  <= tags_q.mem;
            tags_q.mem <= tags_q.exe;

            if (stall) begin
                // Fetch and decode keep their instruction, a bubble goes to execute
                tags_q.exe.vld <= 1'b0;
                tags_q.exe.tag <= tags_q.decode.tag;
            end else begin
                tags_q.exe       <= tags_q.decode;
                tags_q.decode    <= tags_q.fetch;
                tags_q.fetch.vld <= 1'b1;      // Fetch stays busy from here on
                tags_q.fetch.tag <= fetch_ctr;
                fetch_ctr        <= fetch_ctr + tag_w'(1);
            end
        end
    end

    assign tags = tags_q;

    ////////////////////////////////////////////////////////////////////
    // Retire order check
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_seen <= 1'b0;
        end else if (tags_q.wb.vld) begin
            wb_seen <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tags_q.wb.vld) begin
            last_wb_tag <= tags_q.wb.tag;
        end
    end

    // Bubbles may sit between retires but tags never skip or repeat
    a_wb_in_order : assert property (
        @(posedge clk) disable iff (!rst_n)
        tags_q.wb.vld && wb_seen |-> tags_q.wb.tag == last_wb_tag + tag_w'(1)
    );

endmodule

//--- tracker/retire_assembler.sv
// Retire record assembler
`timescale 1ns/1ns

module retire_assembler (
    input  logic                  clk,
    input  logic                  rst_n,
    input  trace_pkg::stage_in_t   stage_q,
    input  logic [3:0]            stall_cnt,
    input  trace_pkg::stage_tags_t tags,
    output logic                  rec_valid,  // One cycle per retired instruction
    output trace_pkg::trace_rec_t  rec
);

    import trace_pkg::*;

    ////////////////////////////////////////////////////////////////////
    // Per tag field tables
    ////////////////////////////////////////////////////////////////////

    logic [15:0] pc_tab  [2**tag_w];
    logic [7:0]  opc_tab [2**tag_w];
    logic [3:0]  stl_tab [2**tag_w];   // Decode stall count
    logic [15:0] res_tab [2**tag_w];
    logic        mwr_tab [2**tag_w];

    // Each stage writes the slot of the instruction it holds
    always_ff @(posedge clk) begin
        if (tags.fetch.vld) begin
            pc_tab[tags.fetch.tag] <= stage_q.fetch_pc;       // Rewritten while held
        end
        if (tags.decode.vld) begin
            opc_tab[tags.decode.tag] <= stage_q.decode_opcode;
        end
        if (tags.decode.vld && !stage_q.stall) begin
            stl_tab[tags.decode.tag] <= stall_cnt;            // Leaving decode
        end
        if (tags.exe.vld) begin
            res_tab[tags.exe.tag] <= stage_q.exe_result;
        end
        if (tags.mem.vld) begin
            mwr_tab[tags.mem.tag] <= stage_q.mem_wr;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Record build at write-back
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= tags.wb.vld;
        end
    end

    // Write-back fields come live from the bus, the rest from the tables
    always_ff @(posedge clk) begin
        if (tags.wb.vld) begin
            rec.tag       <= tags.wb.tag;
            rec.pc        <= pc_tab[tags.wb.tag];
            rec.opcode    <= opc_tab[tags.wb.tag];
            rec.stall_cnt <= stl_tab[tags.wb.tag];
            rec.mem_wr    <= mwr_tab[tags.wb.tag];
            rec.wb_en     <= stage_q.wb_en;
            rec.wb_reg    <= stage_q.wb_reg;
            rec.rsv       <= '0;
            rec.result    <= res_tab[tags.wb.tag];
        end
    end

endmodule

//--- verilog/trace_fifo.sv
// Trace record FIFO
`timescale 1ns/1ns

module trace_fifo (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,      // No back-pressure, dropped when full
    input  trace_pkg::trace_rec_t din,
    input  logic                 pop,
    output trace_pkg::trace_rec_t dout,     // Head record
    output logic [4:0]           level,
    output logic [7:0]           ovf_cnt,   // Dropped pushes, saturates
    input  logic                 ovf_clr
);

    import trace_pkg::*;

    trace_rec_t            mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic                  full;
    logic                  do_push;
    logic                  drop;

    assign full    = level == 5'(fifo_depth);
    assign do_push = push && !full;
    assign drop    = push && full;               // Pop in the same cycle does not help
    assign dout    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            wr_ptr <= wr_ptr + fifo_ptr_w'(do_push);    // Pointers wrap at depth
            rd_ptr <= rd_ptr + fifo_ptr_w'(pop);
            level  <= level + 5'(do_push) - 5'(pop);
        end
    end

    // A clear still counts a drop in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ovf_cnt <= '0;
        end else if (ovf_clr) begin
            ovf_cnt <= {7'd0, drop};
        end else if (drop && ovf_cnt != 8'hff) begin
            ovf_cnt <= ovf_cnt + 8'd1;
        end
    end

    // The host slave must gate its pops on level
    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (!rst_n) pop |-> level != '0
    );

endmodule

//--- verilog/trace_axil_slave.sv
// AXI4-Lite trace host port
`timescale 1ns/1ns

module trace_axil_slave (
    input  logic                 clk,
    input  logic                 rst_n,
    input  trace_pkg::axil_req_t  req,
    output trace_pkg::axil_rsp_t  rsp,
    input  trace_pkg::trace_rec_t head,     // FIFO head
    input  logic [4:0]           level,
    input  logic [7:0]           ovf_cnt,
    output logic                 pop,      // Read of reg_hi with data present
    output logic                 ovf_clr   // Write to reg_stat
);

    import trace_pkg::*;

    trace_rec_u  head_u;
    logic [31:0] stat_word;
    logic [31:0] rd_word;
    logic [1:0]  rd_resp;
    logic        ar_hs, wr_hs, q_empty;
    logic        arready_q, rvalid_q, awready_q, wready_q, bvalid_q;
    logic [31:0] rdata_q;
    logic [1:0]  rresp_q;

    always_comb head_u.rec = head;              // Split into two bus words

    assign q_empty   = level == '0;
    assign stat_word = {16'd0, ovf_cnt, 3'd0, level};
    assign ar_hs     = arready_q && req.arvalid;
    assign wr_hs     = awready_q && req.awvalid && wready_q && req.wvalid;
    assign pop       = ar_hs && req.araddr == reg_hi && !q_empty;
    assign ovf_clr   = wr_hs && req.awaddr == reg_stat;

    // Read decode, record words are an error when nothing is queued
    always_comb begin
        rd_word = '0;
        rd_resp = resp_okay;
        case (req.araddr)
            reg_lo: begin
                if (q_empty) begin
                    rd_resp = resp_slverr;
                end else begin
                    rd_word = head_u.word[0];
                end
            end
            reg_hi: begin
                if (q_empty) begin
                    rd_resp = resp_slverr;
                end else begin
                    rd_word = head_u.word[1];
                end
            end
            reg_stat: rd_word = stat_word;
            default:  rd_word = '0;             // Unmapped reads as zero
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Read channel, one outstanding
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else if (ar_hs) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b1;                  // Data one cycle after address
        end else if (rvalid_q && req.rready) begin
            rvalid_q  <= 1'b0;
            arready_q <= 1'b1;
        end else if (!rvalid_q) begin
            arready_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata_q <= rd_word;
            rresp_q <= rd_resp;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Write channel, address and data taken together
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            bvalid_q  <= 1'b0;
        end else if (wr_hs) begin
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            bvalid_q  <= 1'b1;
        end else if (bvalid_q && req.bready) begin
            bvalid_q  <= 1'b0;
        end else if (!bvalid_q && req.awvalid && req.wvalid) begin
            awready_q <= 1'b1;                  // Both present, accept next cycle
            wready_q  <= 1'b1;
        end
    end

    always_comb begin
        rsp         = '0;
        rsp.arready = arready_q;
        rsp.rvalid  = rvalid_q;
        rsp.rdata   = rdata_q;
        rsp.rresp   = rresp_q;
        rsp.awready = awready_q;
        rsp.wready  = wready_q;
        rsp.bvalid  = bvalid_q;
        rsp.bresp   = resp_okay;                // Writes never fail
    end

endmodule

//--- verilog/pipe_trace_top.sv
// Pipeline trace unit top
`timescale 1ns/1ns

module pipe_trace_top (
    input  logic                clk,
    input  logic                rst_n,
    input  trace_pkg::stage_in_t cpu_in,
    input  trace_pkg::axil_req_t axil_req,
    output trace_pkg::axil_rsp_t axil_rsp
);

    import trace_pkg::*;

    stage_in_t   stage_q;
    logic [3:0]  stall_cnt;
    stage_tags_t tags;
    logic        rec_valid;
    trace_rec_t  rec;
    trace_rec_t  head;
    logic [4:0]  level;
    logic [7:0]  ovf_cnt;
    logic        pop, ovf_clr;

    ////////////////////////////////////////////////////////////////////
    // Capture and tracking
    ////////////////////////////////////////////////////////////////////

    stage_capture u_stage_capture (
        .clk, .rst_n, .cpu_in, .stage_q, .stall_cnt
    );

    // Tags follow the registered stall so they line up with stage_q
    pipe_tag_tracker u_pipe_tag_tracker (
        .clk, .rst_n, .stall(stage_q.stall), .tags
    );

    retire_assembler u_retire_assembler (
        .clk, .rst_n, .stage_q, .stall_cnt, .tags, .rec_valid, .rec
    );

    ////////////////////////////////////////////////////////////////////
    // Queue and host port
    ////////////////////////////////////////////////////////////////////

    trace_fifo u_trace_fifo (
        .clk, .rst_n, .push(rec_valid), .din(rec), .pop, .dout(head),
        .level, .ovf_cnt, .ovf_clr
    );

    trace_axil_slave u_trace_axil_slave (
        .clk, .rst_n, .req(axil_req), .rsp(axil_rsp), .head, .level, .ovf_cnt,
        .pop, .ovf_clr
    );

endmodule

//--- test/tb_trace_model.svh
// Reference pipeline model
`ifndef TB_TRACE_MODEL_SVH
`define TB_TRACE_MODEL_SVH

// One model stage, the record fills in as the instruction moves on
typedef struct packed {
    logic       vld;
    trace_rec_t r;                 // stall_cnt runs while held in decode
} slot_t;

slot_t      pipe [5] = '{default: '0};   // 0 fetch .. 4 write-back
logic [7:0] next_tag    = '0;             // Tag of the next fetched instruction
int         retired     = 0;
int         left_decode = 0;              // Instructions that got past decode
int         exp_ovf     = 0;              // Expected dropped records
trace_rec_t exp_q [$];                    // What the FIFO should hold, head first

// Bus word for the current occupancy, empty stages carry junk
task automatic make_bus(input logic stall, output stage_in_t b);
    logic [63:0] junk;
    junk = {$random(seed), $random(seed)};
    b    = junk[47:0];
    if (pipe[0].vld) b.fetch_pc = pipe[0].r.pc;
    if (pipe[1].vld) b.decode_opcode = pipe[1].r.opcode;
    if (pipe[2].vld) b.exe_result = pipe[2].r.result;
    if (pipe[3].vld) b.mem_wr = pipe[3].r.mem_wr;
    if (pipe[4].vld) begin
        b.wb_en  = pipe[4].r.wb_en;        // Write-back fields go out live
        b.wb_reg = pipe[4].r.wb_reg;
    end
    b.stall = stall;
endtask

// One clock of the pipeline, retire first and then shift
task automatic advance_pipe(input logic stall);
    logic [31:0] rnd_a;
    logic [31:0] rnd_b;
    if (pipe[4].vld) begin
        retired++;
        if (exp_q.size() < fifo_depth) begin
            exp_q.push_back(pipe[4].r);
        end else if (exp_ovf < 255) begin
            exp_ovf++;                     // Queue full, record lost
        end
    end
    pipe[4] = pipe[3];
    pipe[3] = pipe[2];
    if (stall) begin
        pipe[2] = '0;                      // Bubble into execute
        if (pipe[1].r.stall_cnt < 4'(stall_max)) pipe[1].r.stall_cnt++;
    end else begin
        if (pipe[1].vld) left_decode++;
        pipe[2]             = pipe[1];
        pipe[1]             = pipe[0];
        pipe[1].r.stall_cnt = '0;           // Fresh count on entry to decode
        rnd_a               = $random(seed);
        rnd_b               = $random(seed);
        pipe[0]             = '0;
        pipe[0].vld         = 1'b1;
        pipe[0].r.tag       = next_tag;
        pipe[0].r.pc        = rnd_a[15:0];
        pipe[0].r.opcode    = rnd_a[23:16];
        pipe[0].r.wb_reg    = rnd_a[28:24];
        pipe[0].r.mem_wr    = rnd_a[29];
        pipe[0].r.wb_en     = rnd_a[30];
        pipe[0].r.result    = rnd_b[15:0];
        next_tag++;                        // Wraps like the hardware tag
    end
endtask

// Status word as the host should see it once the FIFO caught up
function automatic logic [31:0] exp_stat();
    return {16'd0, 8'(exp_ovf), 3'd0, 5'(exp_q.size())};
endfunction

`endif

//--- test/tb_pipe_trace.sv
// Pipeline trace testbench
`timescale 1ns/1ns

module tb_pipe_trace;

    import trace_pkg::*;

    logic      clk;
    logic      rst_n;
    stage_in_t cpu_in;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;

    integer seed        = 32'he715;
    logic   stall_en    = 1'b0;       // Random stall bursts on
    int     issue_limit = 0;          // Instructions allowed past decode
    int     burst_left  = 0;          // Stall cycles left in the current burst

    `include "tb_trace_model.svh"

    pipe_trace_top u_pipe_trace_top (
        .clk, .rst_n, .cpu_in, .axil_req, .axil_rsp
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_rec(input string name, input trace_rec_t exp, input trace_rec_t act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_stat(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s expected %b actual %b", name, exp, act));
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // CPU side
    ////////////////////////////////////////////////////////////////////

    // Front end held once the issue budget is used up, back end drains
    task automatic pick_stall(output logic st);
        if (!stall_en) burst_left = 0;
        if (left_decode >= issue_limit) begin
            st = 1'b1;
        end else begin
            // About one cycle in four ends up stalled
            if (burst_left == 0 && stall_en && ($random(seed) & 31) == 0) begin
                burst_left = 1 + {$random(seed)} % 20;     // 1 to 20 cycles
            end
            st = burst_left != 0;
            if (st) burst_left--;
        end
    endtask

    task automatic drive_cpu();
        logic      st;
        stage_in_t b;
        pick_stall(st);
        make_bus(st, b);
        cpu_in = b;
        advance_pipe(st);
    endtask

    initial begin : cpu_side
        rst_n        = 1'b0;
        cpu_in       = '0;
        cpu_in.stall = 1'b1;
        repeat (2) @(posedge clk);
        #5;
        rst_n = 1'b1;
        forever begin
            drive_cpu();                    // Model state lines up with stage_q
            @(posedge clk);
            #5;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Host side
    ////////////////////////////////////////////////////////////////////

    // Handshakes sampled mid cycle, taken at the next rising edge
    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int   t;
        logic done;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        done             = 1'b0;
        for (t = 0; t < 200 && !done; t++) begin
            @(negedge clk);
            done = axil_rsp.arready;
            @(posedge clk);
            #5;
        end
        axil_req.arvalid = 1'b0;
        if (!done) fail_run("read address was never accepted");
        axil_req.rready = 1'b1;
        done            = 1'b0;
        for (t = 0; t < 200 && !done; t++) begin
            @(negedge clk);
            if (axil_rsp.rvalid) begin
                done = 1'b1;
                data = axil_rsp.rdata;
                resp = axil_rsp.rresp;
            end
            @(posedge clk);
            #5;
        end
        axil_req.rready = 1'b0;
        if (!done) fail_run("read data never came back");
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int   t;
        logic done;
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        done             = 1'b0;
        for (t = 0; t < 200 && !done; t++) begin
            @(negedge clk);
            done = axil_rsp.awready && axil_rsp.wready;   // Slave takes both at once
            @(posedge clk);
            #5;
        end
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        if (!done) fail_run("write address and data were never accepted");
        axil_req.bready = 1'b1;
        done            = 1'b0;
        for (t = 0; t < 200 && !done; t++) begin
            @(negedge clk);
            if (axil_rsp.bvalid) begin
                done = 1'b1;
                resp = axil_rsp.bresp;
            end
            @(posedge clk);
            #5;
        end
        axil_req.bready = 1'b0;
        if (!done) fail_run("write response never came back");
    endtask

    task automatic verify_status(input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(reg_stat, data, resp);
        check_resp(name, resp_okay, resp);
        check_stat(name, exp_stat(), data);
    endtask

    // Low word first, the high word read pops the head
    task automatic read_record(input string name);
        logic [31:0] lo;
        logic [31:0] hi;
        logic [1:0]  resp;
        trace_rec_u  got;
        if (exp_q.size() == 0) fail_run("record read while the model expects none");
        axi_read(reg_lo, lo, resp);
        check_resp(name, resp_okay, resp);
        axi_read(reg_hi, hi, resp);
        check_resp(name, resp_okay, resp);
        got.word[0] = lo;
        got.word[1] = hi;
        check_rec(name, exp_q.pop_front(), got.rec);
    endtask

    task automatic drain_fifo(input string name);
        while (exp_q.size() > 0) read_record(name);
        verify_status(name);
    endtask

    task automatic wait_retired();
        int t;
        for (t = 0; t < 200 && retired != issue_limit; t++) @(posedge clk);
        if (retired != issue_limit) fail_run("instructions did not retire within 200 cycles");
        repeat (4) @(posedge clk);          // Retire to FIFO push is three edges
        #5;
    endtask

    task automatic wait_record();
        logic [31:0] data;
        logic [1:0]  resp;
        int          t;
        data = '0;
        for (t = 0; t < 200 && data[4:0] == 5'd0; t++) axi_read(reg_stat, data, resp);
        if (data[4:0] == 5'd0) fail_run("no record reached the FIFO during traffic");
    endtask

    task automatic run_batch(input int count, input string name);
        issue_limit += count;
        wait_retired();
        drain_fifo(name);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////

    initial begin : main_test
        logic [31:0] data;
        logic [1:0]  resp;
        int          n;
        axil_req = '0;
        repeat (3) @(posedge clk);
        #5;

        // Empty queue reads
        axi_read(reg_lo, data, resp);
        check_resp("empty reg_lo", resp_slverr, resp);
        check_stat("empty reg_lo", 32'd0, data);
        axi_read(reg_hi, data, resp);
        check_resp("empty reg_hi", resp_slverr, resp);
        check_stat("empty reg_hi", 32'd0, data);
        verify_status("empty status");

        for (n = 0; n < 4; n++) run_batch(10, "no stall");
        stall_en = 1'b1;
        for (n = 0; n < 6; n++) run_batch(10, "random stall");

        // 20 retires with no reads, level 16 and 4 dropped
        stall_en    = 1'b0;
        issue_limit += 20;
        wait_retired();
        verify_status("overflow");
        axi_write(reg_stat, 32'd0, resp);
        check_resp("overflow clear", resp_okay, resp);
        exp_ovf = 0;
        verify_status("after clear");
        drain_fifo("first sixteen");

        // Reads while records keep arriving
        stall_en    = 1'b1;
        issue_limit += 16;
        for (n = 0; n < 16; n++) begin
            wait_record();
            read_record("traffic");
        end
        wait_retired();
        verify_status("end of traffic");

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+test
common/trace_pkg.sv
verilog/stage_capture.sv
tracker/pipe_tag_tracker.sv
tracker/retire_assembler.sv
verilog/trace_fifo.sv
verilog/trace_axil_slave.sv
verilog/pipe_trace_top.sv
test/tb_pipe_trace.sv

//--- run.sh
#!/usr/bin/env bash
# Build the trace unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module tb_pipe_trace \
    -Mdir obj_dir && ./obj_dir/Vtb_pipe_trace || exit 1
